// File: ooo_issue.f
+incdir+.
rv32i_types_pkg.sv
instr_decoder.sv
regfile_scoreboard.sv
reorder_buffer.sv
ooo_issue_top.sv
ooo_issue_sva.sv
ooo_issue_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ooo_issue_tb
FILELIST  = ooo_issue.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: ooo_issue_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_settings.svh"

module ooo_issue_tb
  import rv32i_types_pkg::*;
();

  localparam int max_cycles = 2000;

  typedef struct packed {
    rob_tag_t    tag;
    logic        writes_rd;
    logic [4:0]  rd;
    logic        done;
    logic [31:0] value;
  } entry_t;

  logic          clk;
  logic          rst;
  logic          instr_valid;
  instr_word_u   instr;
  logic          wb_valid;
  wb_t           wb;
  logic          issue_fire;
  issue_bundle_t issue;
  logic          commit_valid;
  commit_t       commit;
  logic          rob_full;

  // reference model state
  logic [31:0]   model_reg  [32];
  rob_tag_t      model_tag  [32];
  logic          model_busy [32];
  entry_t        model_q    [$];
  rob_tag_t      model_tail;

  logic [31:0]   seed;
  string         test_name;
  int            check_cnt;
  int            error_cnt;
  int            cycle_cnt;

  ooo_issue_top DUT (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .wb_valid     (wb_valid),
    .wb           (wb),
    .issue_fire   (issue_fire),
    .issue        (issue),
    .commit_valid (commit_valid),
    .commit       (commit),
    .rob_full     (rob_full)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] enc(logic [6:0] op, logic [4:0] rd, logic [4:0] rs1,
                                      logic [4:0] rs2);
    return {7'b1011001, rs2, rs1, 3'b010, rd, op};
  endfunction

  // immediate layouts straight from the rv32i encoding
  function automatic decoded_t ref_decode(logic [31:0] w);
    decoded_t d;
    d.rs1_s  = w[19:15];
    d.rs2_s  = w[24:20];
    d.rd_s   = w[11:7];
    d.opcode = w[6:0];
    case (w[6:0])
      imm_opcode:   d.imm = {{20{w[31]}}, w[31:20]};
      store_opcode: d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      br_opcode:    d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      lui_opcode:   d.imm = {w[31:12], 12'd0};
      default:      d.imm = '0;
    endcase
    d.writes_rd = (w[6:0] != store_opcode) && (w[6:0] != br_opcode) && (w[11:7] != 5'd0);
    return d;
  endfunction

  function automatic issue_bundle_t predict_issue(logic [31:0] w);
    issue_bundle_t b;
    b.dec       = ref_decode(w);
    b.tag       = model_tail;
    b.rs1_v     = model_reg[b.dec.rs1_s];
    b.rs1_ready = !model_busy[b.dec.rs1_s];
    b.rs1_rob   = model_tag[b.dec.rs1_s];
    b.rs2_v     = model_reg[b.dec.rs2_s];
    b.rs2_ready = !model_busy[b.dec.rs2_s];
    b.rs2_rob   = model_tag[b.dec.rs2_s];
    return b;
  endfunction

  function automatic logic [31:0] rand_instr();
    logic [31:0] w;
    w = lcg_next();
    // registers kept in x0..x7 so renames collide often
    w[11:10] = 2'b00;
    w[19:18] = 2'b00;
    w[24:23] = 2'b00;
    case ((lcg_next() >> 16) % 6)
      0:       w[6:0] = op_opcode;
      1:       w[6:0] = imm_opcode;
      2:       w[6:0] = store_opcode;
      3:       w[6:0] = br_opcode;
      4:       w[6:0] = lui_opcode;
      default: w[6:0] = 7'b0001111;
    endcase
    return w;
  endfunction

  // mode 0 no writeback, 1 random pending entry, 2 oldest pending entry
  function automatic int pick_pending(int mode);
    int pending[$];
    for (int i = 0; i < model_q.size(); i++) begin
      if (!model_q[i].done) begin
        pending.push_back(i);
      end
    end
    if (mode == 0 || pending.size() == 0) begin
      return -1;
    end
    if (mode == 2) begin
      return pending[0];
    end
    return pending[(lcg_next() >> 16) % pending.size()];
  endfunction

  task automatic check_value(string what, logic [159:0] expected, logic [159:0] actual);
    check_cnt++;
    if (expected !== actual) begin
      error_cnt++;
      $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic step(logic iv, logic [31:0] w, int mode);
    int idx;
    @(posedge clk);
    idx = pick_pending(mode);
    instr_valid <= iv;
    instr       <= w;
    wb_valid    <= (idx >= 0);
    if (idx >= 0) begin
      wb.tag   <= model_q[idx].tag;
      wb.value <= lcg_next();
    end
  endtask

  task automatic drain();
    while (model_q.size() != 0) begin
      step(1'b0, 32'd0, 1);
    end
  endtask

  task automatic release_reset();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  endtask

  // checks outputs, then advances the model across the coming edge
  task automatic compare_and_update();
    issue_bundle_t exp_issue;
    commit_t       exp_commit;
    entry_t        e;
    logic          exp_full;
    logic          exp_fire;
    logic          exp_cv;
    exp_full  = (model_q.size() == `ROB_DEPTH);
    exp_fire  = instr_valid && !exp_full;
    exp_cv    = 1'b0;
    if (model_q.size() != 0) begin
      exp_cv = model_q[0].done;
    end
    exp_issue = predict_issue(instr);
    check_value("rob_full", 160'(exp_full), 160'(rob_full));
    check_value("issue_fire", 160'(exp_fire), 160'(issue_fire));
    check_value("commit_valid", 160'(exp_cv), 160'(commit_valid));
    if (exp_fire) begin
      check_value("issue bundle", 160'(exp_issue), 160'(issue));
    end
    // commit first so a same-edge rename keeps busy and tag
    if (exp_cv) begin
      e = model_q.pop_front();
      exp_commit.regfile_we = e.writes_rd;
      exp_commit.rd_s       = e.rd;
      exp_commit.rd_v       = e.value;
      exp_commit.rob        = e.tag;
      check_value("commit", 160'(exp_commit), 160'(commit));
      if (e.writes_rd) begin
        model_reg[e.rd] = e.value;
        if (model_busy[e.rd] && model_tag[e.rd] == e.tag) begin
          model_busy[e.rd] = 1'b0;
        end
      end
    end
    if (wb_valid) begin
      for (int i = 0; i < model_q.size(); i++) begin
        if (model_q[i].tag == wb.tag) begin
          e          = model_q[i];
          e.done     = 1'b1;
          e.value    = wb.value;
          model_q[i] = e;
        end
      end
    end
    if (exp_fire) begin
      e.tag       = model_tail;
      e.writes_rd = exp_issue.dec.writes_rd;
      e.rd        = exp_issue.dec.rd_s;
      e.done      = 1'b0;
      e.value     = '0;
      model_q.push_back(e);
      if (e.writes_rd) begin
        model_busy[e.rd] = 1'b1;
        model_tag[e.rd]  = model_tail;
      end
      model_tail = model_tail + rob_tag_t'(1);
    end
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (!rst) begin
        compare_and_update();
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", max_cycles);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    seed        = 32'h1383_a4f0;
    check_cnt   = 0;
    error_cnt   = 0;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    wb_valid    = 1'b0;
    wb          = '0;
    model_tail  = '0;
    for (int i = 0; i < 32; i++) begin
      model_reg[i]  = '0;
      model_tag[i]  = '0;
      model_busy[i] = 1'b0;
    end
    release_reset();

    test_name = "reset_read";
    step(1'b1, enc(op_opcode, 5'd0, 5'd1, 5'd2), 0);
    step(1'b1, enc(op_opcode, 5'd0, 5'd31, 5'd30), 0);
    step(1'b1, enc(store_opcode, 5'd3, 5'd0, 5'd17), 0);
    drain();

    // store, branch and x0 destinations must not rename
    test_name = "rename_visible";
    step(1'b1, enc(op_opcode, 5'd5, 5'd1, 5'd2), 0);
    step(1'b1, enc(imm_opcode, 5'd6, 5'd5, 5'd5), 0);
    step(1'b1, enc(store_opcode, 5'd5, 5'd5, 5'd7), 0);
    step(1'b1, enc(br_opcode, 5'd9, 5'd5, 5'd6), 0);
    step(1'b1, enc(op_opcode, 5'd0, 5'd5, 5'd6), 0);
    step(1'b1, enc(op_opcode, 5'd10, 5'd0, 5'd9), 0);
    drain();

    test_name = "ooo_writeback";
    for (int k = 1; k <= 6; k++) begin
      step(1'b1, enc(imm_opcode, 5'(k), 5'(k - 1), 5'd0), 0);
    end
    drain();
    for (int k = 1; k <= 6; k += 2) begin
      step(1'b1, enc(op_opcode, 5'd0, 5'(k), 5'(k + 1)), 0);
    end
    drain();

    // older commit of x7 while a younger producer is in flight
    test_name = "older_commit";
    step(1'b1, enc(op_opcode, 5'd7, 5'd1, 5'd2), 0);
    step(1'b1, enc(imm_opcode, 5'd7, 5'd3, 5'd0), 0);
    step(1'b0, 32'd0, 2);
    step(1'b0, 32'd0, 0);
    step(1'b0, 32'd0, 0);
    step(1'b1, enc(op_opcode, 5'd8, 5'd7, 5'd7), 0);
    drain();
    step(1'b1, enc(op_opcode, 5'd8, 5'd7, 5'd7), 0);
    drain();

    test_name = "rob_full";
    repeat (`ROB_DEPTH + 2) step(1'b1, enc(imm_opcode, 5'd11, 5'd11, 5'd0), 0);
    step(1'b1, enc(imm_opcode, 5'd11, 5'd11, 5'd0), 2);
    repeat (3) step(1'b1, enc(imm_opcode, 5'd12, 5'd11, 5'd0), 0);
    drain();

    test_name = "random_mix";
    repeat (150) begin
      r = lcg_next();
      step(r[31] | r[30], rand_instr(), r[29] ? 1 : 0);
    end
    drain();
    step(1'b0, 32'd0, 0);

    $display("checks: %0d  errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ooo_issue_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_settings.svh"

module ooo_issue_sva (
  input logic                  clk,
  input logic                  rst,
  input logic [`ROB_TAG_W:0]   count,
  input logic                  commit_valid,
  input logic [`ROB_TAG_W-1:0] head,
  input logic                  issue_fire,
  input logic [`ROB_TAG_W-1:0] alloc_tag,
  input logic                  wb_valid,
  input logic [`ROB_TAG_W-1:0] wb_tag,
  input logic                  x0_busy
);

  // entries that got a result since they were allocated
  logic [`ROB_DEPTH-1:0] result_seen;

  always_ff @(posedge clk) begin
    if (rst) begin
      result_seen <= '0;
    end else begin
      if (wb_valid) begin
        result_seen[wb_tag] <= 1'b1;
      end
      if (issue_fire) begin
        result_seen[alloc_tag] <= 1'b0;
      end
    end
  end

  count_in_range: assert property (@(posedge clk) disable iff (rst) count <= `ROB_DEPTH)
    else $error("reorder buffer count above its depth");

  // x0 is hardwired and never gets a producer
  x0_never_busy: assert property (@(posedge clk) disable iff (rst) !x0_busy)
    else $error("x0 marked busy in the scoreboard");

  commit_needs_done: assert property (@(posedge clk) disable iff (rst)
    commit_valid |-> result_seen[head])
    else $error("commit presented for a head entry without a result");

endmodule

bind reorder_buffer ooo_issue_sva rob_sva (
  .clk          (clk),
  .rst          (rst),
  .count        (count),
  .commit_valid (commit_valid),
  .head         (head),
  .issue_fire   (issue_fire),
  .alloc_tag    (tail),
  .wb_valid     (wb_valid),
  .wb_tag       (wb.tag),
  .x0_busy      (1'b0)
);

bind regfile_scoreboard ooo_issue_sva sb_sva (
  .clk          (clk),
  .rst          (rst),
  .count        ('0),
  .commit_valid (1'b0),
  .head         ('0),
  .issue_fire   (1'b0),
  .alloc_tag    ('0),
  .wb_valid     (1'b0),
  .wb_tag       ('0),
  .x0_busy      (busy_arr[0])
);

`default_nettype wire

// File: ooo_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_settings.svh"

module ooo_issue_top
  import rv32i_types_pkg::*;
(
  input  logic          clk,
  input  logic          rst,

  input  logic          instr_valid,
  input  instr_word_u   instr,

  input  logic          wb_valid,
  input  wb_t           wb,

  output logic          issue_fire,
  output issue_bundle_t issue,

  output logic          commit_valid,
  output commit_t       commit,

  output logic          rob_full
);

  decoded_t                dec;
  rob_tag_t                alloc_tag;
  logic [31:0]             rs1_v;
  logic [31:0]             rs2_v;
  logic                    rs1_ready;
  logic                    rs2_ready;
  rob_tag_t                rs1_rob;
  rob_tag_t                rs2_rob;
  logic [`ROB_TAG_W-1:0]   issue_tag;

  // a full rob drops the request
  assign issue_fire = instr_valid && !rob_full;
  assign issue_tag  = alloc_tag;

  instr_decoder u_decoder (
    .instr (instr),
    .dec   (dec)
  );

  reorder_buffer u_rob (
    .clk          (clk),
    .rst          (rst),
    .issue_fire   (issue_fire),
    .dec          (dec),
    .wb_valid     (wb_valid),
    .wb           (wb),
    .alloc_tag    (alloc_tag),
    .rob_full     (rob_full),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

  regfile_scoreboard u_scoreboard (
    .clk          (clk),
    .rst          (rst),
    .issue_fire   (issue_fire),
    .dec          (dec),
    .alloc_tag    (alloc_tag),
    .commit_valid (commit_valid),
    .commit       (commit),
    .rs1_v        (rs1_v),
    .rs2_v        (rs2_v),
    .rs1_ready    (rs1_ready),
    .rs2_ready    (rs2_ready),
    .rs1_rob      (rs1_rob),
    .rs2_rob      (rs2_rob)
  );

  always_comb begin
    issue.tag       = issue_tag;
    issue.rs1_v     = rs1_v;
    issue.rs1_ready = rs1_ready;
    issue.rs1_rob   = rs1_rob;
    issue.rs2_v     = rs2_v;
    issue.rs2_ready = rs2_ready;
    issue.rs2_rob   = rs2_rob;
    issue.dec       = dec;
  end

endmodule

`default_nettype wire

// File: reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_settings.svh"

module reorder_buffer
  import rv32i_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // allocation
  input  logic     issue_fire,
  input  decoded_t dec,

  // out of order completion
  input  logic     wb_valid,
  input  wb_t      wb,

  output rob_tag_t alloc_tag,
  output logic     rob_full,

  // in order retirement
  output logic     commit_valid,
  output commit_t  commit
);

  // control state
  logic [`ROB_DEPTH-1:0] done_arr;
  rob_tag_t              head;
  rob_tag_t              tail;
  logic [`ROB_TAG_W:0]   count;

  // entry payload
  logic                  writes_rd_arr [`ROB_DEPTH];
  logic [4:0]            rd_s_arr      [`ROB_DEPTH];
  logic [31:0]           value_arr     [`ROB_DEPTH];

  assign alloc_tag = tail;
  assign rob_full  = (count == `ROB_DEPTH);

  // head retires as soon as its result is in
  assign commit_valid = (count != '0) && done_arr[head];

  always_comb begin
    commit.regfile_we = writes_rd_arr[head];
    commit.rd_s       = rd_s_arr[head];
    commit.rd_v       = value_arr[head];
    commit.rob        = head;
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      done_arr <= '0;
      head     <= '0;
      tail     <= '0;
      count    <= '0;
    end else begin
      if (commit_valid) begin
        done_arr[head] <= 1'b0;
        head           <= head + 1'b1;
      end

      if (wb_valid) begin
        done_arr[wb.tag] <= 1'b1;
      end

      if (issue_fire) begin
        done_arr[tail] <= 1'b0;
        tail           <= tail + 1'b1;
      end

      case ({issue_fire, commit_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue_fire) begin
      writes_rd_arr[tail] <= dec.writes_rd;
      rd_s_arr[tail]      <= dec.rd_s;
    end
    if (wb_valid) begin
      value_arr[wb.tag] <= wb.value;
    end
  end

endmodule

`default_nettype wire

// File: regfile_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module regfile_scoreboard
  import rv32i_types_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  // new producer from the issue side
  input  logic        issue_fire,
  input  decoded_t    dec,
  input  rob_tag_t    alloc_tag,

  // retirement from the reorder buffer
  input  logic        commit_valid,
  input  commit_t     commit,

  // operand answer for the issuing instruction
  output logic [31:0] rs1_v,
  output logic [31:0] rs2_v,
  output logic        rs1_ready,
  output logic        rs2_ready,
  output rob_tag_t    rs1_rob,
  output rob_tag_t    rs2_rob
);

  logic [31:0] register_arr [32];
  rob_tag_t    tag_arr      [32];
  logic        busy_arr     [32];

  logic        commit_we;
  logic        commit_owns;
  logic        issue_we;

  assign commit_we = commit_valid && commit.regfile_we;

  // only the youngest producer may release the register
  assign commit_owns = busy_arr[commit.rd_s] && (tag_arr[commit.rd_s] == commit.rob);

  assign issue_we = issue_fire && dec.writes_rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        register_arr[i] <= '0;
        tag_arr[i]      <= '0;
        busy_arr[i]     <= 1'b0;
      end
    end else begin
      if (commit_we) begin
        register_arr[commit.rd_s] <= commit.rd_v;
        if (commit_owns) begin
          busy_arr[commit.rd_s] <= 1'b0;
        end
      end

      // issue comes last so a rename at the same edge wins
      if (issue_we) begin
        tag_arr[dec.rd_s]  <= alloc_tag;
        busy_arr[dec.rd_s] <= 1'b1;
      end
    end
  end

  // operands see state from before the edge
  always_comb begin
    rs1_v     = register_arr[dec.rs1_s];
    rs2_v     = register_arr[dec.rs2_s];
    rs1_ready = !busy_arr[dec.rs1_s];
    rs2_ready = !busy_arr[dec.rs2_s];
    rs1_rob   = tag_arr[dec.rs1_s];
    rs2_rob   = tag_arr[dec.rs2_s];
  end

endmodule

`default_nettype wire

// File: instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
  import rv32i_types_pkg::*;
(
  input  instr_word_u instr,
  output decoded_t    dec
);

  logic [6:0] opcode;
  logic       no_dest;

  assign opcode = instr.r_view.opcode;

  // stores and branches have no destination register
  assign no_dest = (opcode == store_opcode) || (opcode == br_opcode);

  always_comb begin
    dec.rs1_s  = instr.r_view.rs1;
    dec.rs2_s  = instr.r_view.rs2;
    dec.rd_s   = instr.r_view.rd;
    dec.opcode = opcode;

    case (opcode)
      imm_opcode: begin
        dec.imm = {{20{instr.r_view.funct7[6]}}, instr.r_view.funct7, instr.r_view.rs2};
      end
      store_opcode: begin
        dec.imm = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi, instr.s_view.imm_lo};
      end
      br_opcode: begin
        // b-type scrambles the s-type immediate bits
        dec.imm = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_lo[0],
                   instr.s_view.imm_hi[5:0], instr.s_view.imm_lo[4:1], 1'b0};
      end
      lui_opcode: begin
        dec.imm = {instr.r_view.funct7, instr.r_view.rs2, instr.r_view.rs1,
                   instr.r_view.funct3, 12'd0};
      end
      default: begin
        // register-register and the rest carry no immediate
        dec.imm = '0;
      end
    endcase

    // x0 is never renamed
    dec.writes_rd = !no_dest && (instr.r_view.rd != 5'd0);
  end

endmodule

`default_nettype wire

// File: rv32i_types_pkg.sv
`default_nettype none

`include "rob_settings.svh"

package rv32i_types_pkg;

  localparam logic [6:0] store_opcode = 7'b0100011;
  localparam logic [6:0] br_opcode    = 7'b1100011;
  localparam logic [6:0] op_opcode    = 7'b0110011;
  localparam logic [6:0] imm_opcode   = 7'b0010011;
  localparam logic [6:0] lui_opcode   = 7'b0110111;

  typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

  // R/I layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  // S/B layout, immediate split around rs fields
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_view_t;

  typedef union packed {
    r_view_t r_view;
    s_view_t s_view;
  } instr_word_u;

  typedef struct packed {
    logic [4:0]  rs1_s;
    logic [4:0]  rs2_s;
    logic [4:0]  rd_s;
    logic [6:0]  opcode;
    logic [31:0] imm;
    logic        writes_rd;
  } decoded_t;

  typedef struct packed {
    rob_tag_t    tag;
    logic [31:0] rs1_v;
    logic        rs1_ready;
    rob_tag_t    rs1_rob;
    logic [31:0] rs2_v;
    logic        rs2_ready;
    rob_tag_t    rs2_rob;
    decoded_t    dec;
  } issue_bundle_t;

  typedef struct packed {
    rob_tag_t    tag;
    logic [31:0] value;
  } wb_t;

  typedef struct packed {
    logic        regfile_we;
    logic [4:0]  rd_s;
    logic [31:0] rd_v;
    rob_tag_t    rob;
  } commit_t;

endpackage

`default_nettype wire

// File: rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// reorder buffer entries, kept at 2 ** ROB_TAG_W
`define ROB_DEPTH 8

// width of a reorder buffer tag
`define ROB_TAG_W 3

`endif
